//--- all.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_regs.sv
hdl/cpu_addr.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
verif/tb_cpu.sv

//--- hdl/cpu_addr.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_addr import cpu_pkg::*; (
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  input  logic                   pc_inc,
  input  logic                   pc_load,
  input  logic                   branch_take,
  input  logic                   ea_load_lo,
  input  logic                   ea_load_hi,
  input  reg_sel_e               ea_index,
  input  logic [`CPU_DATA_W-1:0] x_value,
  input  logic [`CPU_DATA_W-1:0] y_value,
  input  logic                   operand_load,
  input  addr_sel_e              addr_sel,
  output logic [`CPU_ADDR_W-1:0] mem_address,
  output logic [`CPU_DATA_W-1:0] operand
);

  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] ea;
  logic [`CPU_ADDR_W-1:0] branch_target;
  logic [`CPU_DATA_W-1:0] index;

  always_comb
  begin
    case (ea_index)
      reg_x:   index = x_value;
      reg_y:   index = y_value;
      default: index = '0;
    endcase
  end

  // Branch offset is signed, relative to the next opcode
  assign branch_target = pc + {{(`CPU_ADDR_W-`CPU_DATA_W){operand[`CPU_DATA_W-1]}}, operand};

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      pc <= `CPU_RESET_VECTOR;
    end
    else if (pc_load)
    begin
      pc <= ea;
    end
    else if (branch_take)
    begin
      pc <= branch_target;
    end
    else if (pc_inc)
    begin
      pc <= pc + 1'b1;
    end
  end

  // Low byte alone is a zero page address
  always_ff @(posedge raw_clk)
  begin
    if (ea_load_lo)
    begin
      ea <= {{(`CPU_ADDR_W-`CPU_DATA_W){1'b0}}, mem_rdata};
    end
    else if (ea_load_hi)
    begin
      ea <= {mem_rdata, ea[`CPU_DATA_W-1:0]} + index;
    end
    if (operand_load)
    begin
      operand <= mem_rdata;
    end
  end

  assign mem_address = (addr_sel == addr_ea) ? ea : pc;

endmodule

//--- hdl/cpu_alu.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_alu import cpu_pkg::*; (
  input  alu_op_e                op,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  logic                   carry_in,
  output logic [`CPU_DATA_W-1:0] result,
  output logic                   negative,
  output logic                   zero,
  output logic                   carry_out
);

  logic [`CPU_DATA_W-1:0] addend;
  logic                   add_carry;
  logic [`CPU_DATA_W:0]   sum;

  // Subtraction is A + ~B + C, compare forces the carry in
  always_comb
  begin
    addend = b;
    add_carry = carry_in;
    if (op == alu_sbc || op == alu_cmp)
    begin
      addend = ~b;
    end
    if (op == alu_cmp)
    begin
      add_carry = 1'b1;
    end
  end

  assign sum = {1'b0, a} + {1'b0, addend} + add_carry;

  always_comb
  begin
    result = a;
    carry_out = 1'b0;
    case (op)
      alu_or:  result = a | b;
      alu_and: result = a & b;
      alu_eor: result = a ^ b;
      alu_adc, alu_sbc, alu_cmp:
      begin
        result = sum[`CPU_DATA_W-1:0];
        carry_out = sum[`CPU_DATA_W];
      end
      alu_inc: result = a + 1'b1;
      alu_dec: result = a - 1'b1;
      default: result = a;
    endcase
  end

  assign negative = result[`CPU_DATA_W-1];
  assign zero = (result == '0);

endmodule

//--- hdl/cpu_control.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_control import cpu_pkg::*; (
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  input  logic [`CPU_FLAG_W-1:0] flags,
  output logic                   mem_read,
  output logic                   mem_write,
  output alu_op_e                alu_op,
  output reg_sel_e               src_sel,
  output reg_sel_e               dst_sel,
  output logic                   flag_write,
  output logic                   carry_write,
  output logic                   carry_value,
  output logic                   pc_inc,
  output logic                   pc_load,
  output logic                   branch_take,
  output logic                   ea_load_lo,
  output logic                   ea_load_hi,
  output reg_sel_e               ea_index,
  output logic                   operand_load,
  output addr_sel_e              addr_sel,
  output logic                   halted,
  output logic                   illegal
);

  typedef enum logic [2:0] {
    md_implied, md_imm, md_zp, md_abs, md_abx, md_aby, md_jump, md_illegal
  } mode_e;

  state_e   state;
  state_e   next_state;
  opcode_e  ir;
  mode_e    mode;
  alu_op_e  dec_alu;
  reg_sel_e dec_src;
  reg_sel_e dec_dst;
  logic     group_01;
  logic     is_store;
  logic     is_arith;
  logic     branch_ok;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= st_fetch_op;
      ir <= op_brk;
    end
    else
    begin
      state <= next_state;
      if (state == st_latch_op)
      begin
        ir <= opcode_e'(mem_rdata);
      end
    end
  end

  // Addressing mode, and illegal for anything outside the subset
  always_comb
  begin
    case (ir)
      op_ora_imm, op_and_imm, op_eor_imm, op_adc_imm, op_lda_imm, op_cmp_imm,
      op_sbc_imm, op_ldx_imm, op_ldy_imm, op_beq, op_bne, op_bcs, op_bcc:
        mode = md_imm;
      op_ora_zp, op_and_zp, op_eor_zp, op_adc_zp, op_sta_zp, op_lda_zp,
      op_cmp_zp, op_sbc_zp:
        mode = md_zp;
      op_ora_abs, op_and_abs, op_eor_abs, op_adc_abs, op_sta_abs, op_lda_abs,
      op_cmp_abs, op_sbc_abs:
        mode = md_abs;
      op_ora_abx, op_and_abx, op_eor_abx, op_adc_abx, op_sta_abx, op_lda_abx,
      op_cmp_abx, op_sbc_abx:
        mode = md_abx;
      op_ora_aby, op_and_aby, op_eor_aby, op_adc_aby, op_sta_aby, op_lda_aby,
      op_cmp_aby, op_sbc_aby:
        mode = md_aby;
      op_jmp_abs:
        mode = md_jump;
      op_brk, op_clc, op_sec, op_inx, op_iny, op_dex, op_dey,
      op_tax, op_tay, op_txa, op_tya:
        mode = md_implied;
      default:
        mode = md_illegal;
    endcase
  end

  // Accumulator group keeps its operation in bits 7:5
  assign group_01 = (ir[1:0] == 2'b01);
  assign is_store = group_01 && (ir[7:5] == 3'd4);
  assign is_arith = group_01 && (ir[7:5] == 3'd3 || ir[7:5] >= 3'd6);

  always_comb
  begin
    case (ir)
      op_inx, op_iny:         dec_alu = alu_inc;
      op_dex, op_dey:         dec_alu = alu_dec;
      op_ldx_imm, op_ldy_imm: dec_alu = alu_or;
      default:                dec_alu = alu_pass;
    endcase
    if (group_01)
    begin
      case (ir[7:5])
        3'd1:    dec_alu = alu_and;
        3'd2:    dec_alu = alu_eor;
        3'd3:    dec_alu = alu_adc;
        3'd6:    dec_alu = alu_cmp;
        3'd7:    dec_alu = alu_sbc;
        // ORA, and LDA with a zero source
        default: dec_alu = alu_or;
      endcase
    end
  end

  always_comb
  begin
    case (ir)
      op_inx, op_dex, op_txa: dec_src = reg_x;
      op_iny, op_dey, op_tya: dec_src = reg_y;
      op_tax, op_tay:         dec_src = reg_a;
      default: dec_src = (group_01 && ir[7:5] != 3'd5) ? reg_a : reg_none;
    endcase
    case (ir)
      op_ldx_imm, op_inx, op_dex, op_tax: dec_dst = reg_x;
      op_ldy_imm, op_iny, op_dey, op_tay: dec_dst = reg_y;
      op_txa, op_tya:                     dec_dst = reg_a;
      default: dec_dst = (group_01 && !is_store && ir[7:5] != 3'd6) ? reg_a : reg_none;
    endcase
  end

  always_comb
  begin
    case (ir)
      op_beq:  branch_ok = flags[`FLAG_Z];
      op_bne:  branch_ok = !flags[`FLAG_Z];
      op_bcs:  branch_ok = flags[`FLAG_C];
      op_bcc:  branch_ok = !flags[`FLAG_C];
      default: branch_ok = 1'b0;
    endcase
  end

  always_comb
  begin
    next_state = state;
    mem_read = 1'b0;
    mem_write = 1'b0;
    dst_sel = reg_none;
    flag_write = 1'b0;
    carry_write = 1'b0;
    pc_inc = 1'b0;
    pc_load = 1'b0;
    branch_take = 1'b0;
    ea_load_lo = 1'b0;
    ea_load_hi = 1'b0;
    ea_index = reg_none;
    operand_load = 1'b0;
    addr_sel = addr_pc;
    case (state)
      st_fetch_op:
      begin
        mem_read = 1'b1;
        next_state = st_latch_op;
      end
      st_latch_op:
      begin
        pc_inc = 1'b1;
        next_state = st_decode;
      end
      st_decode:
      begin
        if (mode == md_illegal)
          next_state = st_illegal;
        else if (mode == md_implied)
          next_state = st_execute;
        else
          next_state = st_fetch_lo;
      end
      st_fetch_lo:
      begin
        mem_read = 1'b1;
        next_state = st_latch_lo;
      end
      st_latch_lo:
      begin
        // Same byte serves as immediate, offset or address low
        ea_load_lo = 1'b1;
        operand_load = 1'b1;
        pc_inc = 1'b1;
        if (mode == md_imm || (mode == md_zp && is_store))
          next_state = st_execute;
        else if (mode == md_zp)
          next_state = st_read_operand;
        else
          next_state = st_fetch_hi;
      end
      st_fetch_hi:
      begin
        mem_read = 1'b1;
        next_state = st_latch_hi;
      end
      st_latch_hi:
      begin
        ea_load_hi = 1'b1;
        pc_inc = 1'b1;
        if (mode == md_abx)
          ea_index = reg_x;
        else if (mode == md_aby)
          ea_index = reg_y;
        if (is_store || mode == md_jump)
          next_state = st_execute;
        else
          next_state = st_read_operand;
      end
      st_read_operand:
      begin
        mem_read = 1'b1;
        addr_sel = addr_ea;
        next_state = st_latch_operand;
      end
      st_latch_operand:
      begin
        operand_load = 1'b1;
        addr_sel = addr_ea;
        next_state = st_execute;
      end
      st_execute:
      begin
        next_state = st_fetch_op;
        if (is_store)
          next_state = st_store;
        else if (ir == op_brk)
          next_state = st_halted;
        else
        begin
          dst_sel = dec_dst;
          flag_write = (dec_dst != reg_none) || is_arith;
          carry_write = is_arith || ir == op_clc || ir == op_sec;
          branch_take = branch_ok;
          pc_load = (mode == md_jump);
        end
      end
      st_store:
      begin
        mem_write = 1'b1;
        addr_sel = addr_ea;
        next_state = st_fetch_op;
      end
      // Halted and illegal hold until reset
      default: ;
    endcase
  end

  assign alu_op = dec_alu;
  assign src_sel = dec_src;
  assign carry_value = (ir == op_sec);
  assign halted = (state == st_halted);
  assign illegal = (state == st_illegal);

endmodule

//--- hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Byte-wide data bus and register width
`define CPU_DATA_W 8

// Address bus width, 64 KB space
`define CPU_ADDR_W 16

// Address of the first opcode fetch
`define CPU_RESET_VECTOR 16'h0200

// Packed flag vector, carry in the low bit
`define CPU_FLAG_W 3
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_N 2

`endif

//--- hdl/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

  // Supported opcodes under their 6502 encodings
  typedef enum logic [`CPU_DATA_W-1:0] {
    op_brk     = 8'h00,
    // Accumulator group, layout aaabbb01
    op_ora_imm = 8'h09, op_ora_zp = 8'h05, op_ora_abs = 8'h0d,
    op_ora_abx = 8'h1d, op_ora_aby = 8'h19,
    op_and_imm = 8'h29, op_and_zp = 8'h25, op_and_abs = 8'h2d,
    op_and_abx = 8'h3d, op_and_aby = 8'h39,
    op_eor_imm = 8'h49, op_eor_zp = 8'h45, op_eor_abs = 8'h4d,
    op_eor_abx = 8'h5d, op_eor_aby = 8'h59,
    op_adc_imm = 8'h69, op_adc_zp = 8'h65, op_adc_abs = 8'h6d,
    op_adc_abx = 8'h7d, op_adc_aby = 8'h79,
    op_sta_zp  = 8'h85, op_sta_abs = 8'h8d,
    op_sta_abx = 8'h9d, op_sta_aby = 8'h99,
    op_lda_imm = 8'ha9, op_lda_zp = 8'ha5, op_lda_abs = 8'had,
    op_lda_abx = 8'hbd, op_lda_aby = 8'hb9,
    op_cmp_imm = 8'hc9, op_cmp_zp = 8'hc5, op_cmp_abs = 8'hcd,
    op_cmp_abx = 8'hdd, op_cmp_aby = 8'hd9,
    op_sbc_imm = 8'he9, op_sbc_zp = 8'he5, op_sbc_abs = 8'hed,
    op_sbc_abx = 8'hfd, op_sbc_aby = 8'hf9,
    // Index loads and register ops
    op_ldx_imm = 8'ha2, op_ldy_imm = 8'ha0,
    op_inx = 8'he8, op_iny = 8'hc8, op_dex = 8'hca, op_dey = 8'h88,
    op_tax = 8'haa, op_tay = 8'ha8, op_txa = 8'h8a, op_tya = 8'h98,
    // Flags, branches and jump
    op_clc = 8'h18, op_sec = 8'h38,
    op_beq = 8'hf0, op_bne = 8'hd0, op_bcs = 8'hb0, op_bcc = 8'h90,
    op_jmp_abs = 8'h4c
  } opcode_e;

  typedef enum logic [3:0] {
    st_fetch_op, st_latch_op, st_decode,
    st_fetch_lo, st_latch_lo, st_fetch_hi, st_latch_hi,
    st_read_operand, st_latch_operand,
    st_execute, st_store, st_halted, st_illegal
  } state_e;

  typedef enum logic [3:0] {
    alu_or, alu_and, alu_eor, alu_adc, alu_sbc,
    alu_cmp, alu_pass, alu_inc, alu_dec
  } alu_op_e;

  typedef enum logic [1:0] {reg_none, reg_a, reg_x, reg_y} reg_sel_e;

  typedef enum logic {addr_pc, addr_ea} addr_sel_e;

endpackage

//--- hdl/cpu_regs.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_regs import cpu_pkg::*; (
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  reg_sel_e               dst_sel,
  input  reg_sel_e               src_sel,
  input  logic [`CPU_DATA_W-1:0] result,
  input  logic                   negative,
  input  logic                   zero,
  input  logic                   carry_out,
  input  logic                   flag_write,
  input  logic                   carry_write,
  input  logic                   carry_value,
  output logic [`CPU_DATA_W-1:0] src_value,
  output logic [`CPU_DATA_W-1:0] x_value,
  output logic [`CPU_DATA_W-1:0] y_value,
  output logic [`CPU_FLAG_W-1:0] flags
);

  logic [`CPU_DATA_W-1:0] acc;
  logic [`CPU_DATA_W-1:0] x_reg;
  logic [`CPU_DATA_W-1:0] y_reg;
  logic                   flag_n;
  logic                   flag_z;
  logic                   flag_c;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      acc <= '0;
      x_reg <= '0;
      y_reg <= '0;
      flag_n <= 1'b0;
      flag_z <= 1'b0;
      flag_c <= 1'b0;
    end
    else
    begin
      case (dst_sel)
        reg_a:   acc <= result;
        reg_x:   x_reg <= result;
        reg_y:   y_reg <= result;
        default: ;
      endcase
      if (flag_write)
      begin
        flag_n <= negative;
        flag_z <= zero;
      end
      // ALU carry for arithmetic, fixed value for CLC and SEC
      if (carry_write)
      begin
        flag_c <= flag_write ? carry_out : carry_value;
      end
    end
  end

  // Unselected source reads as zero so loads can OR the operand in
  always_comb
  begin
    case (src_sel)
      reg_a:   src_value = acc;
      reg_x:   src_value = x_reg;
      reg_y:   src_value = y_reg;
      default: src_value = '0;
    endcase
  end

  assign x_value = x_reg;
  assign y_value = y_reg;

  assign flags[`FLAG_N] = flag_n;
  assign flags[`FLAG_Z] = flag_z;
  assign flags[`FLAG_C] = flag_c;

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_top import cpu_pkg::*; (
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  output logic [`CPU_ADDR_W-1:0] mem_address,
  output logic [`CPU_DATA_W-1:0] mem_wdata,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   halted,
  output logic                   illegal
);

  alu_op_e                alu_op;
  reg_sel_e               src_sel;
  reg_sel_e               dst_sel;
  reg_sel_e               ea_index;
  addr_sel_e              addr_sel;
  logic                   flag_write;
  logic                   carry_write;
  logic                   carry_value;
  logic                   pc_inc;
  logic                   pc_load;
  logic                   branch_take;
  logic                   ea_load_lo;
  logic                   ea_load_hi;
  logic                   operand_load;
  logic [`CPU_FLAG_W-1:0] flags;
  logic [`CPU_DATA_W-1:0] src_value;
  logic [`CPU_DATA_W-1:0] x_value;
  logic [`CPU_DATA_W-1:0] y_value;
  logic [`CPU_DATA_W-1:0] operand;
  logic [`CPU_DATA_W-1:0] result;
  logic                   negative;
  logic                   zero;
  logic                   carry_out;

  cpu_control u_control (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .flags        (flags),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .alu_op       (alu_op),
    .src_sel      (src_sel),
    .dst_sel      (dst_sel),
    .flag_write   (flag_write),
    .carry_write  (carry_write),
    .carry_value  (carry_value),
    .pc_inc       (pc_inc),
    .pc_load      (pc_load),
    .branch_take  (branch_take),
    .ea_load_lo   (ea_load_lo),
    .ea_load_hi   (ea_load_hi),
    .ea_index     (ea_index),
    .operand_load (operand_load),
    .addr_sel     (addr_sel),
    .halted       (halted),
    .illegal      (illegal)
  );

  // Selected register against the latched operand
  cpu_alu u_alu (
    .op        (alu_op),
    .a         (src_value),
    .b         (operand),
    .carry_in  (flags[`FLAG_C]),
    .result    (result),
    .negative  (negative),
    .zero      (zero),
    .carry_out (carry_out)
  );

  cpu_regs u_regs (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .dst_sel      (dst_sel),
    .src_sel      (src_sel),
    .result       (result),
    .negative     (negative),
    .zero         (zero),
    .carry_out    (carry_out),
    .flag_write   (flag_write),
    .carry_write  (carry_write),
    .carry_value  (carry_value),
    .src_value    (src_value),
    .x_value      (x_value),
    .y_value      (y_value),
    .flags        (flags)
  );

  cpu_addr u_addr (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .pc_inc       (pc_inc),
    .pc_load      (pc_load),
    .branch_take  (branch_take),
    .ea_load_lo   (ea_load_lo),
    .ea_load_hi   (ea_load_hi),
    .ea_index     (ea_index),
    .x_value      (x_value),
    .y_value      (y_value),
    .operand_load (operand_load),
    .addr_sel     (addr_sel),
    .mem_address  (mem_address),
    .operand      (operand)
  );

  // STA drives the accumulator out through the source mux
  assign mem_wdata = src_value;

endmodule

//--- verif/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;

  localparam int clk_period = 100;
  localparam int test_count = 6;
  localparam int cycles_per_test = 400;

  // 6502 encodings used by the test programs
  localparam logic [7:0]
    op_brk = 8'h00, op_jmp = 8'h4c, op_bad = 8'h02,
    op_ora_imm = 8'h09, op_and_imm = 8'h29, op_eor_imm = 8'h49,
    op_adc_imm = 8'h69, op_sbc_imm = 8'he9, op_cmp_imm = 8'hc9,
    op_lda_imm = 8'ha9, op_ldx_imm = 8'ha2, op_ldy_imm = 8'ha0,
    op_lda_zp = 8'ha5, op_lda_abs = 8'had, op_lda_abx = 8'hbd, op_lda_aby = 8'hb9,
    op_sta_zp = 8'h85, op_sta_abs = 8'h8d, op_sta_aby = 8'h99,
    op_inx = 8'he8, op_iny = 8'hc8, op_dex = 8'hca, op_dey = 8'h88,
    op_tax = 8'haa, op_tay = 8'ha8, op_txa = 8'h8a, op_tya = 8'h98,
    op_clc = 8'h18, op_sec = 8'h38,
    op_beq = 8'hf0, op_bne = 8'hd0, op_bcs = 8'hb0, op_bcc = 8'h90;

  logic        raw_clk = 1'b0;
  logic        button_reset;
  logic [7:0]  mem_rdata;
  logic [15:0] mem_address;
  logic [7:0]  mem_wdata;
  logic        mem_read;
  logic        mem_write;
  logic        halted;
  logic        illegal;

  logic [7:0]  mem [0:65535];
  logic [23:0] exp_writes [$];
  logic [15:0] pc_asm;
  logic [7:0]  ref_a;
  logic [7:0]  ref_x;
  logic [7:0]  ref_y;
  logic        ref_z;
  logic        ref_c;
  string       test_name;
  int          test_errors;
  int          tests_failed;

  cpu_top u_dut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .halted       (halted),
    .illegal      (illegal)
  );

  always #(clk_period / 2) raw_clk = ~raw_clk;

  // Read data appears the cycle after the strobe
  always @(posedge raw_clk)
  begin
    if (mem_read)
      mem_rdata <= mem[mem_address];
    if (button_reset && mem_write)
      mem[mem_address] <= mem_wdata;
  end

  always @(posedge raw_clk)
  begin
    if (button_reset)
    begin
      assert (!(mem_read && mem_write))
      else
      begin
        $display("test %s: read and write strobes high in the same cycle", test_name);
        test_errors++;
      end
      assert (!((halted || illegal) && (mem_read || mem_write)))
      else
      begin
        $display("test %s: bus strobe issued after the core stopped", test_name);
        test_errors++;
      end
    end
  end

  // Every write must be the next one the model predicted
  always @(posedge raw_clk)
  begin
    if (button_reset && mem_write)
    begin
      if (exp_writes.size() == 0)
      begin
        $display("test %s: unexpected write of %02h to %04h", test_name, mem_wdata,
                 mem_address);
        test_errors++;
      end
      else
      begin
        assert ({mem_address, mem_wdata} == exp_writes[0])
        else
        begin
          $display("mismatch %s: expected %02h at %04h, actual %02h at %04h", test_name,
                   exp_writes[0][7:0], exp_writes[0][23:8], mem_wdata, mem_address);
          test_errors++;
        end
        exp_writes.delete(0);
      end
    end
  end

  function automatic logic [7:0] rand_byte();
    return 8'($urandom);
  endfunction

  task automatic emit(input logic [7:0] b);
    mem[pc_asm] = b;
    pc_asm = pc_asm + 16'd1;
  endtask

  task automatic set_zero(input logic [7:0] v);
    ref_z = (v == 8'h00);
  endtask

  // Accumulator group by the aaa field of the opcode
  task automatic model_acc(input logic [2:0] op3, input logic [7:0] b);
    logic [8:0] sum;
    sum = '0;
    case (op3)
      3'd0: ref_a = ref_a | b;
      3'd1: ref_a = ref_a & b;
      3'd2: ref_a = ref_a ^ b;
      3'd3: sum = {1'b0, ref_a} + {1'b0, b} + ref_c;
      3'd5: ref_a = b;
      3'd6: sum = {1'b0, ref_a} + {1'b0, ~b} + 9'd1;
      3'd7: sum = {1'b0, ref_a} + {1'b0, ~b} + ref_c;
      default: ;
    endcase
    if (op3 == 3'd3 || op3 == 3'd7)
      ref_a = sum[7:0];
    if (op3 == 3'd3 || op3 == 3'd6 || op3 == 3'd7)
      ref_c = sum[8];
    set_zero(op3 == 3'd6 ? sum[7:0] : ref_a);
  endtask

  task automatic asm_imm(input logic [7:0] opc, input logic [7:0] val);
    emit(opc);
    emit(val);
    if (opc == op_ldx_imm)
    begin
      ref_x = val;
      set_zero(ref_x);
    end
    else if (opc == op_ldy_imm)
    begin
      ref_y = val;
      set_zero(ref_y);
    end
    else
      model_acc(opc[7:5], val);
  endtask

  // A cleared live flag marks code that the run skips
  task automatic asm_mem(input logic [7:0] opc, input logic [15:0] addr, input bit live);
    logic [15:0] ea;
    emit(opc);
    emit(addr[7:0]);
    case (opc[4:2])
      3'b001: ea = {8'h00, addr[7:0]};
      3'b111: ea = addr + ref_x;
      3'b110: ea = addr + ref_y;
      default: ea = addr;
    endcase
    if (opc[4:2] != 3'b001)
      emit(addr[15:8]);
    if (live && opc[7:5] == 3'd4)
      exp_writes.push_back({ea, ref_a});
    else if (live)
      model_acc(opc[7:5], mem[ea]);
  endtask

  task automatic asm_implied(input logic [7:0] opc);
    emit(opc);
    case (opc)
      op_inx: ref_x = ref_x + 8'd1;
      op_dex: ref_x = ref_x - 8'd1;
      op_tax: ref_x = ref_a;
      op_iny: ref_y = ref_y + 8'd1;
      op_dey: ref_y = ref_y - 8'd1;
      op_tay: ref_y = ref_a;
      op_txa: ref_a = ref_x;
      op_tya: ref_a = ref_y;
      op_clc: ref_c = 1'b0;
      op_sec: ref_c = 1'b1;
      default: ;
    endcase
    case (opc)
      op_inx, op_dex, op_tax: set_zero(ref_x);
      op_iny, op_dey, op_tay: set_zero(ref_y);
      op_txa, op_tya: set_zero(ref_a);
      default: ;
    endcase
  endtask

  task automatic asm_jmp(input logic [15:0] target);
    emit(op_jmp);
    emit(target[7:0]);
    emit(target[15:8]);
  endtask

  // Each branch jumps over a two-byte store
  task automatic branch_block(input logic [7:0] base);
    logic [7:0] opc;
    logic       taken;
    for (int i = 0; i < 4; i++)
    begin
      opc = (i == 0) ? op_beq : (i == 1) ? op_bne : (i == 2) ? op_bcs : op_bcc;
      taken = (i == 0) ? ref_z : (i == 1) ? !ref_z : (i == 2) ? ref_c : !ref_c;
      emit(opc);
      emit(8'h02);
      asm_mem(op_sta_zp, {8'h00, base + 8'(i)}, !taken);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    @(posedge raw_clk);
    button_reset <= 1'b0;
    for (int i = 0; i < 65536; i++)
      mem[i] = i[7:0] ^ i[15:8] ^ 8'h3c;
    exp_writes.delete();
    ref_a = '0;
    ref_x = '0;
    ref_y = '0;
    ref_z = 1'b0;
    ref_c = 1'b0;
    pc_asm = 16'h0200;
  endtask

  task automatic run_test(input bit expect_illegal);
    repeat (4) @(posedge raw_clk);
    button_reset <= 1'b1;
    while (!(halted || illegal))
      @(posedge raw_clk);
    // Idle cycles let the bus checks see a quiet core
    repeat (8) @(posedge raw_clk);
    if (expect_illegal)
      assert (illegal && !halted)
      else
      begin
        $display("test %s: illegal output not raised alone", test_name);
        test_errors++;
      end
    else
      assert (halted && !illegal)
      else
      begin
        $display("test %s: core did not halt on BRK", test_name);
        test_errors++;
      end
    assert (exp_writes.size() == 0)
    else
    begin
      $display("test %s: %0d expected writes never happened", test_name, exp_writes.size());
      test_errors++;
    end
    if (test_errors != 0)
      tests_failed++;
    $display("test %-16s %s", test_name, test_errors == 0 ? "pass" : "FAIL");
  endtask

  initial
  begin
    #(test_count * cycles_per_test * clk_period);
    $display("timeout: run exceeded %0d cycles", test_count * cycles_per_test);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    logic [7:0] rx;
    logic [7:0] ry;
    logic [7:0] ops [5];
    button_reset = 1'b0;
    mem_rdata = '0;
    tests_failed = 0;
    void'($urandom(22));
    ops = '{op_ora_imm, op_and_imm, op_eor_imm, op_adc_imm, op_sbc_imm};

    start_test("alu_immediate");
    for (int i = 0; i < 5; i++)
    begin
      asm_imm(op_lda_imm, rand_byte());
      if (i >= 3)
        asm_implied(rand_byte() < 8'h80 ? op_clc : op_sec);
      asm_imm(ops[i], rand_byte());
      asm_mem(op_sta_zp, 16'h0020 + 16'(i), 1'b1);
    end
    asm_implied(op_brk);
    run_test(1'b0);

    start_test("load_modes");
    rx = rand_byte();
    ry = rand_byte();
    mem[16'h0040] = rand_byte();
    mem[16'h1234] = rand_byte();
    mem[16'h3300 + rx] = rand_byte();
    // May cross into the next page
    mem[16'h44c0 + ry] = rand_byte();
    asm_mem(op_lda_zp, 16'h0040, 1'b1);
    asm_mem(op_sta_zp, 16'h0030, 1'b1);
    asm_mem(op_lda_abs, 16'h1234, 1'b1);
    asm_mem(op_sta_zp, 16'h0031, 1'b1);
    asm_imm(op_ldx_imm, rx);
    asm_mem(op_lda_abx, 16'h3300, 1'b1);
    asm_mem(op_sta_zp, 16'h0032, 1'b1);
    asm_imm(op_ldy_imm, ry);
    asm_mem(op_lda_aby, 16'h44c0, 1'b1);
    asm_mem(op_sta_zp, 16'h0033, 1'b1);
    asm_mem(op_sta_aby, 16'h0500, 1'b1);
    asm_implied(op_brk);
    run_test(1'b0);

    start_test("branches");
    rx = rand_byte();
    asm_imm(op_lda_imm, rx);
    asm_imm(op_cmp_imm, rx);
    branch_block(8'h50);
    asm_imm(op_cmp_imm, rand_byte());
    branch_block(8'h54);
    asm_implied(op_clc);
    branch_block(8'h58);
    asm_implied(op_sec);
    branch_block(8'h5c);
    asm_imm(op_adc_imm, rand_byte());
    branch_block(8'h60);
    asm_imm(op_sbc_imm, rand_byte());
    branch_block(8'h64);
    asm_implied(op_brk);
    run_test(1'b0);

    start_test("register_ops");
    asm_imm(op_lda_imm, rand_byte());
    asm_implied(op_tax);
    asm_implied(op_tay);
    asm_implied(op_inx);
    asm_implied(op_dey);
    asm_implied(op_txa);
    asm_mem(op_sta_zp, 16'h0070, 1'b1);
    asm_implied(op_tya);
    asm_mem(op_sta_zp, 16'h0071, 1'b1);
    asm_imm(op_ldx_imm, 8'hff);
    asm_implied(op_inx);
    asm_implied(op_txa);
    asm_mem(op_sta_zp, 16'h0072, 1'b1);
    asm_imm(op_ldy_imm, 8'h00);
    asm_implied(op_dey);
    asm_implied(op_tya);
    asm_mem(op_sta_zp, 16'h0073, 1'b1);
    asm_imm(op_ldx_imm, rand_byte());
    asm_implied(op_dex);
    asm_implied(op_txa);
    asm_mem(op_sta_zp, 16'h0074, 1'b1);
    asm_imm(op_ldy_imm, rand_byte());
    asm_implied(op_iny);
    asm_implied(op_tya);
    asm_mem(op_sta_zp, 16'h0075, 1'b1);
    asm_implied(op_brk);
    run_test(1'b0);

    start_test("jump_and_brk");
    asm_imm(op_lda_imm, rand_byte());
    asm_mem(op_sta_zp, 16'h0080, 1'b1);
    // Target lands just past the skipped store
    asm_jmp(pc_asm + 16'd5);
    asm_mem(op_sta_zp, 16'h0081, 1'b0);
    asm_mem(op_sta_abs, 16'h0382, 1'b1);
    asm_implied(op_brk);
    run_test(1'b0);

    start_test("illegal_opcode");
    asm_imm(op_lda_imm, rand_byte());
    asm_mem(op_sta_zp, 16'h0090, 1'b1);
    emit(op_bad);
    asm_mem(op_sta_zp, 16'h0091, 1'b0);
    run_test(1'b1);

    $display("tests %0d, passed %0d, failed %0d", test_count, test_count - tests_failed,
             tests_failed);
    if (tests_failed == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
